/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := core_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* src/core.sv */
`timescale 1ns/100ps

module core import mips_pkg::*; (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  word_t i_instr,
	input  word_t i_read_data,
	output word_t o_instr_addr,
	output word_t o_data_addr,
	output word_t o_write_data,
	output logic  o_mem_write,
	output logic  o_mem_read
);

	word_t if_instr;
	word_t if_next_pc;
	logic mem_pcsrc;
	word_t mem_branch_target;
	logic wb_regwrite;
	reg_addr_t wb_reg;
	word_t wb_data;

	id_ex_if id_ex ();
	ex_mem_if ex_mem ();

	// Data memory is driven straight from EX/MEM.
	assign o_data_addr = ex_mem.alu_result;
	assign o_write_data = ex_mem.store_data;
	assign o_mem_write = ex_mem.memwrite;
	assign o_mem_read = ex_mem.memread;

	fetch u_fetch (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_instr         (i_instr),
		.i_pcsrc         (mem_pcsrc),
		.i_branch_target (mem_branch_target),
		.o_pc            (o_instr_addr),
		.o_instr         (if_instr),
		.o_next_pc       (if_next_pc)
	);

	decode u_decode (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_instr       (if_instr),
		.i_next_pc     (if_next_pc),
		.i_wb_regwrite (wb_regwrite),
		.i_wb_reg      (wb_reg),
		.i_wb_data     (wb_data),
		.id_ex         (id_ex)
	);

	execute u_execute (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.id_ex    (id_ex),
		.ex_mem   (ex_mem)
	);

	mem_stage u_mem_stage (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.ex_mem          (ex_mem),
		.i_read_data     (i_read_data),
		.o_pcsrc         (mem_pcsrc),
		.o_branch_target (mem_branch_target),
		.o_wb_regwrite   (wb_regwrite),
		.o_wb_reg        (wb_reg),
		.o_wb_data       (wb_data)
	);

endmodule

/* src/decode.sv */
`timescale 1ns/100ps
`include "mips_defs.svh"

module decode import mips_pkg::*; (
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  word_t     i_instr,
	input  word_t     i_next_pc,
	input  logic      i_wb_regwrite,
	input  reg_addr_t i_wb_reg,
	input  word_t     i_wb_data,
	id_ex_if.decode   id_ex
);

	opcode_e opcode;
	funct_e funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t imm;
	word_t rs_data;
	word_t rt_data;
	word_t regs [0:`MIPS_NUM_REGS-1];

	logic regwrite, memtoreg, branch, memread, memwrite, regdst, alusrc;
	aluop_e aluop;

	assign opcode = opcode_e'(i_instr[31:26]);
	assign rs = i_instr[25:21];
	assign rt = i_instr[20:16];
	assign rd = i_instr[15:11];
	assign funct = funct_e'(i_instr[5:0]);
	assign imm = {{(`MIPS_WORD_W-16){i_instr[15]}}, i_instr[15:0]};

	// ----------------------------------------
	// Control decode
	// ----------------------------------------
	always_comb begin
		regwrite = 1'b0;
		memtoreg = 1'b0;
		branch = 1'b0;
		memread = 1'b0;
		memwrite = 1'b0;
		regdst = 1'b0;
		alusrc = 1'b0;
		aluop = AOP_MEM;
		case (opcode)
			OP_RTYPE: begin
				regdst = 1'b1;
				regwrite = funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
				aluop = AOP_FUNCT;
			end
			OP_LW: begin
				alusrc = 1'b1;
				memtoreg = 1'b1;
				memread = 1'b1;
				regwrite = 1'b1;
			end
			OP_SW: begin
				alusrc = 1'b1;
				memwrite = 1'b1;
			end
			OP_BEQ: begin
				branch = 1'b1;
				aluop = AOP_BRANCH;
			end
			default: ; // Anything else passes through as a bubble.
		endcase
	end

	// ----------------------------------------
	// Register file
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_wb_regwrite && i_wb_reg != '0)
			regs[i_wb_reg] <= i_wb_data;
	end

	// A write in the same cycle is seen by the read.
	function automatic word_t rf_read(input reg_addr_t idx);
		if (idx == '0)
			return '0;
		if (i_wb_regwrite && idx == i_wb_reg)
			return i_wb_data;
		return regs[idx];
	endfunction

	always_comb begin
		rs_data = rf_read(rs);
		rt_data = rf_read(rt);
	end

	// ID/EX.
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			id_ex.regwrite <= 1'b0;
			id_ex.memtoreg <= 1'b0;
			id_ex.branch <= 1'b0;
			id_ex.memread <= 1'b0;
			id_ex.memwrite <= 1'b0;
			id_ex.regdst <= 1'b0;
			id_ex.alusrc <= 1'b0;
			id_ex.aluop <= AOP_MEM;
		end else begin
			id_ex.regwrite <= regwrite;
			id_ex.memtoreg <= memtoreg;
			id_ex.branch <= branch;
			id_ex.memread <= memread;
			id_ex.memwrite <= memwrite;
			id_ex.regdst <= regdst;
			id_ex.alusrc <= alusrc;
			id_ex.aluop <= aluop;
		end
	end

	always_ff @(posedge i_clk) begin
		id_ex.next_pc <= i_next_pc;
		id_ex.rs_data <= rs_data;
		id_ex.rt_data <= rt_data;
		id_ex.imm <= imm;
		id_ex.rt <= rt;
		id_ex.rd <= rd;
		id_ex.funct <= funct;
	end

endmodule

/* src/execute.sv */
`timescale 1ns/100ps

module execute import mips_pkg::*; (
	input  logic      i_clk,
	input  logic      i_arst_n,
	id_ex_if.execute  id_ex,
	ex_mem_if.execute ex_mem
);

	alu_fn_e alu_fn;
	word_t operand_b;
	word_t alu_out;

	// ----------------------------------------
	// ALU control and ALU
	// ----------------------------------------
	always_comb begin
		case (id_ex.aluop)
			AOP_BRANCH: alu_fn = ALU_SUB;
			AOP_FUNCT: begin
				case (id_ex.funct)
					FN_SUB: alu_fn = ALU_SUB;
					FN_AND: alu_fn = ALU_AND;
					FN_OR: alu_fn = ALU_OR;
					FN_SLT: alu_fn = ALU_SLT;
					default: alu_fn = ALU_ADD;
				endcase
			end
			default: alu_fn = ALU_ADD;
		endcase
	end

	assign operand_b = id_ex.alusrc ? id_ex.imm : id_ex.rt_data;

	always_comb begin
		case (alu_fn)
			ALU_SUB: alu_out = id_ex.rs_data - operand_b;
			ALU_AND: alu_out = id_ex.rs_data & operand_b;
			ALU_OR: alu_out = id_ex.rs_data | operand_b;
			ALU_SLT: alu_out = word_t'($signed(id_ex.rs_data) < $signed(operand_b));
			default: alu_out = id_ex.rs_data + operand_b;
		endcase
	end

	// EX/MEM.
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ex_mem.regwrite <= 1'b0;
			ex_mem.memtoreg <= 1'b0;
			ex_mem.branch <= 1'b0;
			ex_mem.memread <= 1'b0;
			ex_mem.memwrite <= 1'b0;
		end else begin
			ex_mem.regwrite <= id_ex.regwrite;
			ex_mem.memtoreg <= id_ex.memtoreg;
			ex_mem.branch <= id_ex.branch;
			ex_mem.memread <= id_ex.memread;
			ex_mem.memwrite <= id_ex.memwrite;
		end
	end

	always_ff @(posedge i_clk) begin
		ex_mem.zero <= (alu_out == '0);
		ex_mem.branch_target <= id_ex.next_pc + (id_ex.imm << 2); // Word offset from PC+4.
		ex_mem.alu_result <= alu_out;
		ex_mem.store_data <= id_ex.rt_data;
		ex_mem.dest <= id_ex.regdst ? id_ex.rd : id_ex.rt;
	end

endmodule

/* src/fetch.sv */
`timescale 1ns/100ps
`include "mips_defs.svh"

module fetch import mips_pkg::*; (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  word_t i_instr,
	input  logic  i_pcsrc,
	input  word_t i_branch_target,
	output word_t o_pc,
	output word_t o_instr,
	output word_t o_next_pc
);

	word_t pc;
	word_t pc_plus4;

	assign pc_plus4 = pc + word_t'(4);
	assign o_pc = pc;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc <= `MIPS_RESET_PC;
		end else begin
			pc <= i_pcsrc ? i_branch_target : pc_plus4; // Taken beq from the memory stage.
		end
	end

	// IF/ID. An all-zero word decodes as a no-op.
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_instr <= '0;
		end else begin
			o_instr <= i_instr;
		end
	end

	always_ff @(posedge i_clk) begin
		o_next_pc <= pc_plus4;
	end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage import mips_pkg::*; (
	input  logic      i_clk,
	input  logic      i_arst_n,
	ex_mem_if.mem     ex_mem,
	input  word_t     i_read_data,
	output logic      o_pcsrc,
	output word_t     o_branch_target,
	output logic      o_wb_regwrite,
	output reg_addr_t o_wb_reg,
	output word_t     o_wb_data
);

	logic wb_memtoreg;
	word_t wb_read_data;
	word_t wb_alu_result;

	assign o_pcsrc = ex_mem.branch & ex_mem.zero; // Resolved here. Nothing behind it is flushed.
	assign o_branch_target = ex_mem.branch_target;

	// ----------------------------------------
	// MEM/WB
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_regwrite <= 1'b0;
		end else begin
			o_wb_regwrite <= ex_mem.regwrite;
		end
	end

	always_ff @(posedge i_clk) begin
		wb_memtoreg <= ex_mem.memtoreg;
		wb_read_data <= i_read_data;
		wb_alu_result <= ex_mem.alu_result;
		o_wb_reg <= ex_mem.dest;
	end

	assign o_wb_data = wb_memtoreg ? wb_read_data : wb_alu_result;

endmodule

/* src/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ----------------------------------------
// Core sizing
// ----------------------------------------

// Data and address width.
`define MIPS_WORD_W 32

// Architectural register count. Register 0 reads as zero.
`define MIPS_NUM_REGS 32

// ----------------------------------------
// Fetch
// ----------------------------------------

`define MIPS_RESET_PC 32'h0000_0000 // First fetch address after reset.

`endif

/* src/mips_pkg.sv */
`include "mips_defs.svh"

package mips_pkg;

	typedef logic [`MIPS_WORD_W-1:0] word_t;
	typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] reg_addr_t;

	// Major opcodes of the supported subset.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	// Operation class handed from decode to the ALU control.
	typedef enum logic [1:0] {
		AOP_MEM    = 2'b00, // Address add for lw and sw.
		AOP_BRANCH = 2'b01, // Compare by subtraction for beq.
		AOP_FUNCT  = 2'b10
	} aluop_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_fn_e;

endpackage

/* src/mips_stage_if.sv */
`timescale 1ns/100ps

// ----------------------------------------
// ID/EX pipeline register contents
// ----------------------------------------
interface id_ex_if import mips_pkg::*; ();
	logic regwrite;
	logic memtoreg;
	logic branch;
	logic memread;
	logic memwrite;
	logic regdst;
	logic alusrc;
	aluop_e aluop;
	word_t next_pc;
	word_t rs_data;
	word_t rt_data;
	word_t imm; // Sign-extended offset.
	reg_addr_t rt;
	reg_addr_t rd;
	funct_e funct;

	modport decode (
		output regwrite, memtoreg, branch, memread, memwrite, regdst, alusrc, aluop,
		output next_pc, rs_data, rt_data, imm, rt, rd, funct
	);

	modport execute (
		input regwrite, memtoreg, branch, memread, memwrite, regdst, alusrc, aluop,
		input next_pc, rs_data, rt_data, imm, rt, rd, funct
	);
endinterface

// ----------------------------------------
// EX/MEM pipeline register contents
// ----------------------------------------
interface ex_mem_if import mips_pkg::*; ();
	logic regwrite;
	logic memtoreg;
	logic branch;
	logic memread;
	logic memwrite;
	logic zero;
	word_t branch_target;
	word_t alu_result;
	word_t store_data;
	reg_addr_t dest;

	modport execute (
		output regwrite, memtoreg, branch, memread, memwrite, zero,
		output branch_target, alu_result, store_data, dest
	);

	// The memory strobes, address and store data leave the core directly.
	modport mem (
		input regwrite, memtoreg, branch, zero, branch_target, alu_result, dest
	);
endinterface

/* testbench/core_props.sv */
`timescale 1ns/100ps

module core_props import mips_pkg::*; (
	input logic  i_clk,
	input logic  i_arst_n,
	input word_t i_instr_addr,
	input logic  i_mem_write,
	input logic  i_mem_read,
	input logic  i_pcsrc,
	input word_t i_branch_target
);

	// One instruction is either a load or a store, never both.
	mem_strobes_exclusive: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) !(i_mem_write && i_mem_read)
	) else $error("load and store strobes high in the same cycle");

	strobes_quiet_in_reset: assert property (
		@(posedge i_clk) !i_arst_n |-> !i_mem_write && !i_mem_read
	) else $error("memory strobe high during reset");

	branch_redirects_fetch: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_pcsrc |=> i_instr_addr == $past(i_branch_target)
	) else $error("fetch did not move to the branch target"); // Target shows one cycle later.

endmodule

bind core core_props u_props (
	.i_clk           (i_clk),
	.i_arst_n        (i_arst_n),
	.i_instr_addr    (o_instr_addr),
	.i_mem_write     (o_mem_write),
	.i_mem_read      (o_mem_read),
	.i_pcsrc         (mem_pcsrc),
	.i_branch_target (mem_branch_target)
);

/* testbench/core_tb.sv */
`timescale 1ns/100ps
`include "mips_defs.svh"

module core_tb import mips_pkg::*; ();

	localparam int PROG_LEN = 200;
	localparam int MEM_WORDS = 256;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN = 4;
	localparam int WATCHDOG_NS = (PROG_LEN * 20 + RESET_CYCLES) * 10;

	logic i_clk;
	logic i_arst_n;
	word_t i_instr;
	word_t i_read_data;
	word_t o_instr_addr;
	word_t o_data_addr;
	word_t o_write_data;
	logic o_mem_write;
	logic o_mem_read;

	word_t imem [0:MEM_WORDS-1];
	word_t dmem [0:MEM_WORDS-1];
	word_t ref_mem [0:MEM_WORDS-1];
	word_t ref_regs [0:`MIPS_NUM_REGS-1];
	word_t exp_fetch [$];
	word_t exp_st_addr [$];
	word_t exp_st_data [$];
	word_t exp_ld_addr [$];
	int recent [3]; // Registers written by the last three instructions.
	int st_seen;
	int ld_seen;
	int fetch_errs;
	int store_errs;
	int load_errs;

	core i_dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the program did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

	// ----------------------------------------
	// Program generator
	// ----------------------------------------
	function automatic word_t enc_r(funct_e fn, int rs, int rt, int rd);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t enc_i(opcode_e op, int rs, int rt, int off);
		return {op, 5'(rs), 5'(rt), 16'(off)};
	endfunction

	function automatic word_t enc_unknown();
		logic [5:0] op;
		do
			op = 6'($urandom);
		while (op inside {OP_RTYPE, OP_BEQ, OP_LW, OP_SW});
		return {op, 26'($urandom)};
	endfunction

	function automatic int pick_source();
		int r;
		do
			r = $urandom_range(7, 0);
		while (r != 0 && (r == recent[0] || r == recent[1] || r == recent[2]));
		return r;
	endfunction

	function automatic void note_write(int r);
		recent[2] = recent[1];
		recent[1] = recent[0];
		recent[0] = r;
	endfunction

	task automatic build_program();
		int i;
		int kind;
		int rs;
		int rt;
		int rd;
		int off;
		funct_e fns [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
		for (int k = 0; k < MEM_WORDS; k++) begin
			imem[k] = {6'h3f, 16'h0, 8'(k), 2'b00}; // An unknown opcode makes the fill a no-op.
			dmem[k] = $urandom;
			ref_mem[k] = dmem[k];
		end
		for (i = 0; i < 7; i++) begin
			imem[i] = enc_i(OP_LW, 0, i + 1, 4 * (i + 1));
			note_write(i + 1);
		end
		// A load stored again three slots later and a store of $0.
		imem[7] = enc_i(OP_LW, 0, 1, 800);
		imem[8] = '0;
		imem[9] = '0;
		imem[10] = '0;
		imem[11] = enc_i(OP_SW, 0, 1, 804);
		imem[12] = enc_i(OP_SW, 0, 0, 808);
		recent = '{0, 0, 0};
		i = 13;
		while (i < PROG_LEN - 1) begin
			kind = $urandom_range(9, 0);
			if (kind <= 3) begin
				rs = pick_source();
				rt = pick_source();
				rd = $urandom_range(7, 0);
				imem[i] = enc_r(fns[$urandom_range(4, 0)], rs, rt, rd);
				note_write(rd);
			end else if (kind == 4) begin
				rt = $urandom_range(7, 0);
				imem[i] = enc_i(OP_LW, 0, rt, 4 * $urandom_range(255, 0));
				note_write(rt);
			end else if (kind <= 6) begin
				imem[i] = enc_i(OP_SW, 0, pick_source(), 4 * $urandom_range(255, 0));
				note_write(0);
			end else if (kind == 7 && i <= PROG_LEN - 5) begin
				rs = pick_source();
				rt = $urandom_range(1, 0) ? rs : pick_source();
				off = $urandom_range((PROG_LEN - 2 - i < 8) ? PROG_LEN - 2 - i : 8, 3);
				imem[i] = enc_i(OP_BEQ, rs, rt, off);
				imem[i + 1] = '0;
				imem[i + 2] = '0;
				imem[i + 3] = '0;
				i += 3;
				recent = '{0, 0, 0};
			end else begin
				imem[i] = enc_unknown();
				note_write(0);
			end
			i++;
		end
		imem[PROG_LEN - 1] = enc_i(OP_BEQ, 0, 0, -1);
	endtask

	// ----------------------------------------
	// ISA reference model
	// ----------------------------------------
	task automatic run_model();
		word_t pc;
		word_t instr;
		word_t a;
		word_t b;
		word_t imm_s;
		word_t addr;
		word_t target;
		pc = `MIPS_RESET_PC;
		for (int k = 0; k < `MIPS_NUM_REGS; k++)
			ref_regs[k] = '0;
		for (int steps = 0; steps < 4 * PROG_LEN; steps++) begin
			instr = imem[pc[9:2]];
			a = ref_regs[instr[25:21]];
			b = ref_regs[instr[20:16]];
			imm_s = {{16{instr[15]}}, instr[15:0]};
			addr = a + imm_s;
			target = pc + 4 + (imm_s << 2);
			exp_fetch.push_back(pc);
			case (instr[31:26])
				OP_RTYPE: begin
					case (instr[5:0])
						FN_ADD: ref_regs[instr[15:11]] = a + b;
						FN_SUB: ref_regs[instr[15:11]] = a - b;
						FN_AND: ref_regs[instr[15:11]] = a & b;
						FN_OR: ref_regs[instr[15:11]] = a | b;
						FN_SLT:
							ref_regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				OP_LW: begin
					exp_ld_addr.push_back(addr);
					ref_regs[instr[20:16]] = ref_mem[addr[9:2]];
				end
				OP_SW: begin
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(b);
					ref_mem[addr[9:2]] = b;
				end
				default: ;
			endcase
			ref_regs[0] = '0;
			if (instr[31:26] == OP_BEQ && a == b) begin
				// The three fetches behind a taken beq still happen.
				for (int d = 1; d <= 3; d++)
					exp_fetch.push_back(pc + 4 * d);
				if (target == pc) begin
					for (int d = 0; d <= 3; d++)
						exp_fetch.push_back(pc + 4 * d);
					break;
				end
				pc = target;
			end else begin
				pc = pc + 4;
			end
		end
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	task automatic check_fetch(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error %0t: fetch from %h, expected %h", $time, got, exp);
			fetch_errs++;
		end
	endtask

	task automatic check_store(input word_t got_addr, input word_t got_data,
			input word_t exp_addr, input word_t exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			$display("error %0t: store of %h to %h, expected %h to %h",
				$time, got_data, got_addr, exp_data, exp_addr);
			store_errs++;
		end
	endtask

	task automatic check_load(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error %0t: load from %h, expected %h", $time, got, exp);
			load_errs++;
		end
	endtask

	task automatic watch_memory();
		if (o_mem_write && o_mem_read) begin
			$display("load and store strobes are high together at %0t", $time);
			load_errs++;
		end
		if (o_mem_write) begin
			if (st_seen < exp_st_addr.size())
				check_store(o_data_addr, o_write_data,
					exp_st_addr[st_seen], exp_st_data[st_seen]);
			else begin
				$display("a store at %0t came after the last expected store", $time);
				store_errs++;
			end
			st_seen++;
			dmem[o_data_addr[9:2]] = o_write_data;
		end
		if (o_mem_read) begin
			if (ld_seen < exp_ld_addr.size())
				check_load(o_data_addr, exp_ld_addr[ld_seen]);
			else begin
				$display("a load at %0t came after the last expected load", $time);
				load_errs++;
			end
			ld_seen++;
		end
	endtask

	initial begin
		void'($urandom(32'hc8a9));
		i_arst_n = 1'b0;
		i_instr = '0;
		i_read_data = '0;
		st_seen = 0;
		ld_seen = 0;
		fetch_errs = 0;
		store_errs = 0;
		load_errs = 0;
		recent = '{0, 0, 0};
		build_program();
		run_model();
		repeat (RESET_CYCLES) @(posedge i_clk);
		for (int cyc = 0; cyc < exp_fetch.size() + DRAIN; cyc++) begin
			#1;
			i_arst_n = 1'b1;
			if (cyc < exp_fetch.size())
				check_fetch(o_instr_addr, exp_fetch[cyc]);
			watch_memory();
			i_instr = imem[o_instr_addr[9:2]]; // Both memories answer within the cycle.
			i_read_data = dmem[o_data_addr[9:2]];
			@(posedge i_clk);
		end
		if (st_seen < exp_st_addr.size()) begin
			$display("stores missing: only %0d of %0d were seen", st_seen, exp_st_addr.size());
			store_errs++;
		end
		if (ld_seen < exp_ld_addr.size()) begin
			$display("loads missing: only %0d of %0d were seen", ld_seen, exp_ld_addr.size());
			load_errs++;
		end
		$display("errors: fetch %0d, store %0d, load %0d", fetch_errs, store_errs, load_errs);
		if (fetch_errs + store_errs + load_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+src
src/mips_pkg.sv
src/mips_stage_if.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/mem_stage.sv
src/core.sv
testbench/core_props.sv
testbench/core_tb.sv
